// ==== design/bpParamPkg.sv ====
// Branch predictor geometry: address width, slot layout, counter format
package bpParamPkg;

    // ------------------------------------------------------------
    // Address and fetch block
    // ------------------------------------------------------------
    // Fetch and branch address width
    localparam int addrWidth = 32;

    // Instruction slots per fetch block
    localparam int slotCount = 4;
    localparam int slotBits  = $clog2(slotCount);

    // Slot number sits in address bits 3:2
    localparam int slotLsb   = 2;

    // First hash field starts right above the slot bits
    localparam int indexLsb  = slotLsb + slotBits;

    // ------------------------------------------------------------
    // Counter table
    // ------------------------------------------------------------
    localparam int ctrWidth          = 2;
    // Weakly taken
    localparam int ctrResetValue     = 2;
    localparam int defaultEntryCount = 256;

endpackage

// ==== design/bpTypesPkg.sv ====
// Branch predictor types: repair action encoding and counter values
package bpTypesPkg;

    // ------------------------------------------------------------
    // Table action sent back by the functional unit
    // ------------------------------------------------------------
    // Only phtRepair and phtDirect write a counter
    typedef enum logic [1:0] {
        phtNone   = 2'd0,
        phtRepair = 2'd1,
        phtDirect = 2'd2,
        phtOther  = 2'd3
    } phtAction_e;

    // ------------------------------------------------------------
    // Counter and slot values
    // ------------------------------------------------------------
    // Two-bit saturating counter, also the checkpoint
    typedef logic [bpParamPkg::ctrWidth-1:0] counter_t;

    // Slot number inside a fetch block, selects the bank
    typedef logic [bpParamPkg::slotBits-1:0] slot_t;

    // Saturation limits
    localparam counter_t ctrMax = '1;
    localparam counter_t ctrMin = '0;

    // Upper counter bit gives the direction
    localparam int ctrTakeBit = bpParamPkg::ctrWidth - 1;

endpackage

// ==== design/phtWriteIf.sv ====
// PHT write port: one registered counter write from update stage to table
`timescale 1ns/1ps

interface phtWriteIf #(
    parameter int entryCount = bpParamPkg::defaultEntryCount
);
    import bpTypesPkg::*;

    localparam int idxWidth = $clog2(entryCount);

    // Write strobe, no handshake
    logic                wen;
    // Target slot bank
    slot_t               bank;
    // Hashed entry index inside the bank
    logic [idxWidth-1:0] index;
    // Saturated counter to store
    counter_t            nextCtr;

    // Update stage side
    modport source (
        output wen,
        output bank,
        output index,
        output nextCtr
    );

    // Table side
    modport sink (
        input wen,
        input bank,
        input index,
        input nextCtr
    );

endinterface

// ==== design/phtUpdateStage.sv ====
// PHT update stage: registers a resolved branch as one saturated counter write
`timescale 1ns/1ps

module phtUpdateStage #(
    parameter int entryCount = bpParamPkg::defaultEntryCount
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             needRepair_i,
    input  bpTypesPkg::phtAction_e           action_i,
    input  bpTypesPkg::counter_t             checkPoint_i,
    input  logic [bpParamPkg::addrWidth-1:0] branchPc_i,
    input  logic                             taken_i,
    phtWriteIf.source                        wr
);
    import bpParamPkg::*;
    import bpTypesPkg::*;

    localparam int idxWidth = $clog2(entryCount);

    logic                writeReq;
    logic [idxWidth-1:0] hashIndex;
    slot_t               slotSel;
    logic                atMax;
    logic                atMin;
    counter_t            ctrNext;

    // ------------------------------------------------------------
    // Request decode
    // ------------------------------------------------------------
    assign writeReq = needRepair_i && (action_i == phtRepair || action_i == phtDirect);

    // Bank from the slot bits, entry from two folded address fields
    assign slotSel   = branchPc_i[slotLsb +: slotBits];
    assign hashIndex = branchPc_i[indexLsb +: idxWidth]
                     ^ branchPc_i[indexLsb + idxWidth +: idxWidth];

    // ------------------------------------------------------------
    // Saturating counter step
    // ------------------------------------------------------------
    // Old value comes from the checkpoint carried with the branch
    assign atMax = taken_i && (checkPoint_i == ctrMax);
    assign atMin = !taken_i && (checkPoint_i == ctrMin);

    always_comb begin
        if (atMax || atMin) begin
            ctrNext = checkPoint_i;
        end else if (taken_i) begin
            ctrNext = counter_t'(checkPoint_i + 1'b1);
        end else begin
            ctrNext = counter_t'(checkPoint_i - 1'b1);
        end
    end

    // ------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            wr.wen <= 1'b0;
        end else begin
            wr.wen <= writeReq;
        end
    end

    // Payload only matters while wen is high
    always_ff @(posedge clk) begin
        wr.bank    <= slotSel;
        wr.index   <= hashIndex;
        wr.nextCtr <= ctrNext;
    end

endmodule

// ==== design/phtBank.sv ====
// PHT slot bank: counter array with valid bits and registered, bypassed read
`timescale 1ns/1ps

module phtBank #(
    parameter int entryCount = bpParamPkg::defaultEntryCount
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wen_i,
    input  logic [$clog2(entryCount)-1:0] wIndex_i,
    input  bpTypesPkg::counter_t          wData_i,
    input  logic [$clog2(entryCount)-1:0] rIndex_i,
    output bpTypesPkg::counter_t          rData_o,
    output logic                          predTake_o
);
    import bpParamPkg::*;
    import bpTypesPkg::*;

    // Counter storage and per-entry valid flags
    counter_t              ctrArray [entryCount];
    logic [entryCount-1:0] validBits;

    // Registered read result
    counter_t              rDataQ;
    logic                  rValidQ;

    logic                  bypassHit;

    // ------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------
    // Every counter starts weakly taken, but no entry is valid yet
    always_ff @(posedge clk) begin
        if (!rst) begin
            validBits <= '0;
            for (int k = 0; k < entryCount; k++) begin
                ctrArray[k] <= counter_t'(ctrResetValue);
            end
        end else if (wen_i) begin
            validBits[wIndex_i] <= 1'b1;
            ctrArray[wIndex_i]  <= wData_i;
        end
    end

    // ------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------
    // Same-cycle write to the read entry wins over the stored value
    assign bypassHit = wen_i && (wIndex_i == rIndex_i);

    always_ff @(posedge clk) begin
        if (!rst) begin
            rDataQ  <= '0;
            rValidQ <= 1'b0;
        end else if (bypassHit) begin
            rDataQ  <= wData_i;
            rValidQ <= 1'b1;
        end else begin
            rDataQ  <= ctrArray[rIndex_i];
            rValidQ <= validBits[rIndex_i];
        end
    end

    // Taken only for a trained entry with the upper counter bit set
    assign predTake_o = rValidQ && rDataQ[ctrTakeBit];
    assign rData_o    = rDataQ;

endmodule

// ==== design/patternHistoryTable.sv ====
// Pattern history table: four slot banks looked up in parallel per fetch block
`timescale 1ns/1ps

module patternHistoryTable #(
    parameter int entryCount = bpParamPkg::defaultEntryCount
) (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic [bpParamPkg::addrWidth-1:0]                     fetchPc_i,
    phtWriteIf.sink                                              wr,
    output logic [bpParamPkg::slotCount*bpParamPkg::ctrWidth-1:0] checkPoint_o,
    output logic [bpParamPkg::slotCount-1:0]                     predTake_o
);
    import bpParamPkg::*;
    import bpTypesPkg::*;

    localparam int idxWidth = $clog2(entryCount);

    // ------------------------------------------------------------
    // One bank per instruction slot
    // ------------------------------------------------------------
    for (genvar s = 0; s < slotCount; s++) begin : gSlot
        logic [addrWidth-1:0] slotPc;
        logic [idxWidth-1:0]  rIndex;
        logic                 bankWen;
        counter_t             rData;

        // Address of slot s inside the fetch block
        assign slotPc = {fetchPc_i[addrWidth-1:indexLsb], slot_t'(s), fetchPc_i[slotLsb-1:0]};

        // Same fold as the update stage
        assign rIndex = slotPc[indexLsb +: idxWidth]
                      ^ slotPc[indexLsb + idxWidth +: idxWidth];

        assign bankWen = wr.wen && (wr.bank == slot_t'(s));

        phtBank #(
            .entryCount (entryCount)
        ) uBank (
            .clk        (clk),
            .rst        (rst),
            .wen_i      (bankWen),
            .wIndex_i   (wr.index),
            .wData_i    (wr.nextCtr),
            .rIndex_i   (rIndex),
            .rData_o    (rData),
            .predTake_o (predTake_o[s])
        );

        // Slot s owns bits 2s+1:2s
        assign checkPoint_o[s*ctrWidth +: ctrWidth] = rData;
    end

endmodule

// ==== design/branchPredictor.sv ====
// Branch direction predictor top: update stage feeding the pattern history table
`timescale 1ns/1ps

module branchPredictor #(
    parameter int entryCount = bpParamPkg::defaultEntryCount
) (
    input  logic                                                 clk,
    input  logic                                                 rst,

    // ------------------------------------------------------------
    // Lookup port, one fetch block per cycle
    // ------------------------------------------------------------
    input  logic [bpParamPkg::addrWidth-1:0]                     fetchPc_i,
    output logic [bpParamPkg::slotCount*bpParamPkg::ctrWidth-1:0] checkPoint_o,
    output logic [bpParamPkg::slotCount-1:0]                     predTake_o,

    // ------------------------------------------------------------
    // Update port from branch resolution
    // ------------------------------------------------------------
    input  logic                                                 updNeedRepair_i,
    input  bpTypesPkg::phtAction_e                               updAction_i,
    input  bpTypesPkg::counter_t                                 updCheckPoint_i,
    input  logic [bpParamPkg::addrWidth-1:0]                     updPc_i,
    input  logic                                                 updTaken_i
);

    // Registered counter write between the two stages
    phtWriteIf #(
        .entryCount (entryCount)
    ) phtWr ();

    // Turns a resolved branch into a table write one cycle later
    phtUpdateStage #(
        .entryCount   (entryCount)
    ) uUpdate (
        .clk          (clk),
        .rst          (rst),
        .needRepair_i (updNeedRepair_i),
        .action_i     (updAction_i),
        .checkPoint_i (updCheckPoint_i),
        .branchPc_i   (updPc_i),
        .taken_i      (updTaken_i),
        .wr           (phtWr.source)
    );

    // Counter banks and per-slot lookup
    patternHistoryTable #(
        .entryCount   (entryCount)
    ) uPht (
        .clk          (clk),
        .rst          (rst),
        .fetchPc_i    (fetchPc_i),
        .wr           (phtWr.sink),
        .checkPoint_o (checkPoint_o),
        .predTake_o   (predTake_o)
    );

endmodule

// ==== sim/phtBank_asserts.sv ====
// PHT bank checker: prediction validity, quiet first cycle after reset, known indices
`timescale 1ns/1ps

module phtBankAsserts #(
    parameter int entryCount = bpParamPkg::defaultEntryCount
) (
    input logic                          clk,
    input logic                          rst,
    input logic                          wen_i,
    input logic [$clog2(entryCount)-1:0] wIndex_i,
    input logic [$clog2(entryCount)-1:0] rIndex_i,
    input logic                          predTake_i,
    input logic [entryCount-1:0]         validBits_i
);

    // Read index behind the registered prediction
    logic [$clog2(entryCount)-1:0] rIndexQ;

    always_ff @(posedge clk) begin
        rIndexQ <= rIndex_i;
    end

    // ------------------------------------------------------------
    // Prediction and write behavior
    // ------------------------------------------------------------
    // An untrained entry never predicts taken
    property takeNeedsValid;
        @(posedge clk) disable iff (!rst) predTake_i |-> validBits_i[rIndexQ];
    endproperty

    // Update stage register is still clear on the first active edge
    property quietAfterReset;
        @(posedge clk) $rose(rst) |-> !wen_i;
    endproperty

    // Indices must be known whenever they are used
    property knownWriteIndex;
        @(posedge clk) disable iff (!rst) wen_i |-> !$isunknown(wIndex_i);
    endproperty

    property knownReadIndex;
        @(posedge clk) disable iff (!rst) !$isunknown(rIndex_i);
    endproperty

    aTakeNeedsValid: assert property (takeNeedsValid)
        else $error("Bank predicts taken for an entry that is not valid");
    aQuietAfterReset: assert property (quietAfterReset)
        else $error("Bank written in the first cycle after reset release");
    aKnownWriteIndex: assert property (knownWriteIndex)
        else $error("Bank write index is unknown during a write");
    aKnownReadIndex: assert property (knownReadIndex)
        else $error("Bank read index is unknown");

endmodule

bind phtBank phtBankAsserts #(
    .entryCount  (entryCount)
) uBankAsserts (
    .clk         (clk),
    .rst         (rst),
    .wen_i       (wen_i),
    .wIndex_i    (wIndex_i),
    .rIndex_i    (rIndex_i),
    .predTake_i  (predTake_o),
    .validBits_i (validBits)
);

// ==== sim/tbBranchPredictor.sv ====
// Branch predictor testbench: random lookups and updates checked against a table model
`timescale 1ns/1ps

module tbBranchPredictor;
    import bpParamPkg::*;
    import bpTypesPkg::*;

    localparam int tbEntries = defaultEntryCount;
    localparam int idxWidth  = $clog2(tbEntries);
    // First hash field starts at bit 4, the second right above it
    localparam int hashLsb   = 4;
    localparam logic [31:0] hiMask = ~((32'd1 << (hashLsb + 2 * idxWidth)) - 32'd1);

    localparam int resetCycles   = 8;
    localparam int randomCycles  = 2000;
    localparam int plannedCycles = resetCycles + 16 + 26 + 16 + 16 + 32 + randomCycles + 2;
    localparam int cycleLimit    = 3 * plannedCycles;

    logic                          clk;
    logic                          rst;
    logic [addrWidth-1:0]          fetchPc;
    logic [slotCount*ctrWidth-1:0] checkPoint;
    logic [slotCount-1:0]          predTake;
    logic                          updNeedRepair;
    phtAction_e                    updAction;
    counter_t                      updCheckPoint;
    logic [addrWidth-1:0]          updPc;
    logic                          updTaken;

    // Reference table, one row per slot bank
    counter_t modelCtr   [slotCount][tbEntries];
    logic     modelValid [slotCount][tbEntries];

    // Update presented last cycle, applied at the start of this one
    logic                 pendWrite = 1'b0;
    logic [1:0]           pendSlot;
    logic [idxWidth-1:0]  pendIdx;
    counter_t             pendCtr;

    // Expected result of the lookup presented last cycle
    logic                          expActive = 1'b0;
    logic [slotCount*ctrWidth-1:0] expCp;
    logic [slotCount-1:0]          expTake;
    string                         expTest;

    string       testName;
    logic [31:0] rngState   = 32'h9bf3;
    int          cycleCount = 0;
    int          checkCount = 0;
    int          errCount   = 0;

    branchPredictor #(
        .entryCount      (tbEntries)
    ) DUT (
        .clk             (clk),
        .rst             (rst),
        .fetchPc_i       (fetchPc),
        .checkPoint_o    (checkPoint),
        .predTake_o      (predTake),
        .updNeedRepair_i (updNeedRepair),
        .updAction_i     (updAction),
        .updCheckPoint_i (updCheckPoint),
        .updPc_i         (updPc),
        .updTaken_i      (updTaken)
    );

    always #5 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] xorshiftStep(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] drawRandom();
        rngState = xorshiftStep(rngState);
        return rngState;
    endfunction

    function automatic logic [idxWidth-1:0] entryIndex(input logic [31:0] addr);
        return addr[hashLsb +: idxWidth] ^ addr[hashLsb + idxWidth +: idxWidth];
    endfunction

    // Saturating step of a two-bit counter
    function automatic counter_t nextCounter(input counter_t cp, input logic taken);
        if (taken) begin
            return (cp == 2'd3) ? 2'd3 : cp + 2'd1;
        end
        return (cp == 2'd0) ? 2'd0 : cp - 2'd1;
    endfunction

    function automatic counter_t modelCounterAt(input logic [31:0] addr);
        return modelCtr[addr[3:2]][entryIndex(addr)];
    endfunction

    function automatic counter_t slotField(input logic [7:0] v, input int s);
        return v[s*ctrWidth +: ctrWidth];
    endfunction

    // Few hash values per bank so that entries collide often
    function automatic logic [31:0] randAddr();
        logic [31:0] r;
        logic [31:0] addr;
        r = drawRandom();
        addr = r & hiMask;
        addr[hashLsb +: 2] = r[1:0];
        addr[hashLsb + idxWidth +: 2] = r[3:2];
        addr[3:2] = r[5:4];
        addr[1:0] = r[7:6];
        return addr;
    endfunction

    task automatic compareValue(input string test, input string what,
                                input logic [7:0] expected, input logic [7:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errCount++;
            $display("FAILED %s %s: expected %0h, actual %0h", test, what, expected, actual);
        end
    endtask

    // One cycle: check last lookup, retire last update, drive and predict this one
    task automatic runCycle(input logic [31:0] lookPc, input logic need,
                            input phtAction_e act, input counter_t cp,
                            input logic [31:0] uPc, input logic tk);
        int s;
        logic [idxWidth-1:0] li;
        if (expActive) begin
            compareValue(expTest, "checkpoint", expCp, checkPoint);
            compareValue(expTest, "prediction", 8'(expTake), 8'(predTake));
        end
        if (pendWrite) begin
            modelCtr[pendSlot][pendIdx]   = pendCtr;
            modelValid[pendSlot][pendIdx] = 1'b1;
        end
        fetchPc       = lookPc;
        updNeedRepair = need;
        updAction     = act;
        updCheckPoint = cp;
        updPc         = uPc;
        updTaken      = tk;
        // Slot bits lie below the hash fields, so all slots share one index
        li = entryIndex(lookPc);
        for (s = 0; s < slotCount; s++) begin
            expCp[s*ctrWidth +: ctrWidth] = modelCtr[s][li];
            expTake[s] = modelValid[s][li] && modelCtr[s][li][ctrWidth-1];
        end
        expActive = 1'b1;
        expTest   = testName;
        pendWrite = need && (act == phtRepair || act == phtDirect);
        pendSlot  = uPc[3:2];
        pendIdx   = entryIndex(uPc);
        pendCtr   = nextCounter(cp, tk);
        @(negedge clk);
    endtask

    task automatic lookupOnly(input logic [31:0] lookPc);
        runCycle(lookPc, 1'b0, phtNone, 2'd0, 32'd0, 1'b0);
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        logic [31:0] pc;
        logic [31:0] other;
        logic [31:0] r;
        counter_t    cp;
        counter_t    nc;
        int          s;
        int          k;
        clk           = 1'b0;
        rst           = 1'b0;
        fetchPc       = '0;
        updNeedRepair = 1'b0;
        updAction     = phtNone;
        updCheckPoint = '0;
        updPc         = '0;
        updTaken      = 1'b0;
        for (s = 0; s < slotCount; s++) begin
            for (k = 0; k < tbEntries; k++) begin
                modelCtr[s][k]   = counter_t'(ctrResetValue);
                modelValid[s][k] = 1'b0;
            end
        end
        repeat (resetCycles) @(negedge clk);
        rst = 1'b1;

        testName = "reset_state";
        for (k = 0; k < 16; k++) begin
            lookupOnly(randAddr());
        end

        testName = "saturation";
        pc = randAddr();
        s  = pc[3:2];
        for (k = 0; k < 6; k++) begin
            runCycle(pc, 1'b1, phtDirect, modelCounterAt(pc), pc, 1'b1);
            lookupOnly(pc);
        end
        compareValue(testName, "counter high", 8'd3, 8'(slotField(checkPoint, s)));
        for (k = 0; k < 6; k++) begin
            runCycle(pc, 1'b1, phtRepair, modelCounterAt(pc), pc, 1'b0);
            lookupOnly(pc);
        end
        compareValue(testName, "counter low", 8'd0, 8'(slotField(checkPoint, s)));

        // Every write would change the counter, so only real writes show up
        testName = "write_enable";
        pc = randAddr();
        for (k = 0; k < 8; k++) begin
            cp = (modelCounterAt(pc) == 2'd0) ? 2'd3 : 2'd0;
            runCycle(pc, k[2], phtAction_e'(k[1:0]), cp, pc, 1'b0);
            lookupOnly(pc);
        end

        testName = "slot_routing";
        for (s = 0; s < slotCount; s++) begin
            pc = randAddr();
            other = {pc[31:4], 2'(s), pc[1:0]};
            runCycle(pc, 1'b1, phtDirect, 2'd3, other, 1'b1);
            lookupOnly(pc);
            compareValue(testName, "slot taken", 8'd1, 8'(predTake[s]));
        end

        // Same bits flipped in both fields give the same index
        testName = "hash_alias";
        for (k = 0; k < 4; k++) begin
            pc = randAddr();
            r = drawRandom();
            other = pc ^ (32'(r[1:0]) << hashLsb) ^ (32'(r[1:0]) << (hashLsb + idxWidth));
            other = other ^ (r & hiMask);
            runCycle(pc, 1'b1, phtRepair, 2'd0, other, 1'b0);
            lookupOnly(pc);
            compareValue(testName, "aliased counter", 8'd0, 8'(slotField(checkPoint, pc[3:2])));
        end

        testName = "bypass";
        for (k = 0; k < 16; k++) begin
            r  = drawRandom();
            pc = randAddr();
            cp = r[1:0];
            nc = nextCounter(cp, r[2]);
            s  = pc[3:2];
            runCycle(randAddr(), 1'b1, phtRepair, cp, pc, r[2]);
            lookupOnly(pc);
            compareValue(testName, "new counter", 8'(nc), 8'(slotField(checkPoint, s)));
            compareValue(testName, "new prediction", 8'(nc[1]), 8'(predTake[s]));
        end

        testName = "random_mix";
        for (k = 0; k < randomCycles; k++) begin
            r     = drawRandom();
            pc    = randAddr();
            other = randAddr();
            runCycle(pc, r[0] | r[1], phtAction_e'(r[3:2]), r[5:4], other, r[6]);
        end
        lookupOnly(32'd0);

        $display("Checks: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
design/bpParamPkg.sv
design/bpTypesPkg.sv
design/phtWriteIf.sv
design/phtUpdateStage.sv
design/phtBank.sv
design/patternHistoryTable.sv
design/branchPredictor.sv
sim/phtBank_asserts.sv
sim/tbBranchPredictor.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tbBranchPredictor \
    -f sim.f \
    -o simBranchPredictor

./obj_dir/simBranchPredictor > sim.log 2>&1
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
fi
echo "Simulation failed, see sim.log"
exit 1
